/* bench/tcb_lite_stimulus.txt */
// columns in hex: wen adr siz wdt err
// siz is log2 of the byte count, err is the expected error flag
1 010 0 000000a5 0
0 010 0 00000000 0
1 022 1 0000c3b4 0
0 022 1 00000000 0
1 030 2 8e7d6c5b 0
0 030 2 00000000 0
1 040 0 00000011 0
1 041 0 00000022 0
1 042 1 00004433 0
0 040 2 00000000 0
1 031 1 0000ffff 1
1 032 2 deadbeef 1
0 023 1 00000000 1
0 030 2 00000000 0
0 032 1 00000000 0
1 100 2 01234567 0
1 104 2 89abcdef 0
1 106 1 00005a5a 0
0 100 2 00000000 0
0 104 2 00000000 0
0 107 0 00000000 0
1 3fc 2 cafef00d 0
0 3fe 1 00000000 0
0 3fd 0 00000000 0
0 041 0 00000000 0

/* filelist.f */
design/tcb_lite_pkg.sv
design/tcb_lite_req_queue.sv
design/tcb_lite_mem.sv
design/tcb_lite_rsp_buffer.sv
design/tcb_lite_top.sv
bench/tcb_lite_protocol_sva.sv
bench/tcb_lite_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tcb_lite_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Test failed
PASS_MSG  = Test completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation FAILED"; exit 1; \
	elif grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation PASSED"; \
	else \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tcb_lite_tb.sv */
// testbench for the TCB-Lite subsystem top with clock, reset and file-driven commands
// reference byte memory, random response back-pressure, compare tasks and timeout

`default_nettype none

module tcb_lite_tb
    import tcb_lite_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    // each command line holds five words wen adr siz wdt err
    localparam int MAX_CMD   = 64;
    localparam int STALL_AT  = 13;
    localparam int STALL_CYC = 40;

    logic             mon = 1'b0;
    logic             rst_n;
    logic             cmd_vld;
    logic             cmd_rdy;
    logic             cmd_wen;
    logic [ADR_W-1:0] cmd_adr;
    logic [SIZ_W-1:0] cmd_siz;
    logic [DAT_W-1:0] cmd_wdt;
    logic             rsp_vld;
    logic             rsp_rdy;
    logic             rsp_wen;
    logic [DAT_W-1:0] rsp_rdt;
    logic             rsp_err;

    logic [31:0]      stim_words [0:5*MAX_CMD-1];
    logic [7:0]       ref_mem [2**ADR_W];
    logic             exp_wen_q [$];
    logic             exp_err_q [$];
    logic [DAT_W-1:0] exp_rdt_q [$];

    int          ncmd;
    int          n_acc;
    int          n_rsp;
    int          cyc;
    int          cycle_limit;
    int          stall_left;
    logic        saw_full;
    logic [31:0] rnd_state;

    tcb_lite_top u_dut (
        .mon     (mon),
        .rst_n   (rst_n),
        .cmd_vld (cmd_vld),
        .cmd_rdy (cmd_rdy),
        .cmd_wen (cmd_wen),
        .cmd_adr (cmd_adr),
        .cmd_siz (cmd_siz),
        .cmd_wdt (cmd_wdt),
        .rsp_vld (rsp_vld),
        .rsp_rdy (rsp_rdy),
        .rsp_wen (rsp_wen),
        .rsp_rdt (rsp_rdt),
        .rsp_err (rsp_err)
    );

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic end_with_failure();
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_data(input string name, input logic [DAT_W-1:0] exp,
                              input logic [DAT_W-1:0] act);
        if (act !== exp) begin
            $display("FAILED at %0d ns: %s expected %08h got %08h", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED at %0d ns: %s expected %b got %b", $time, name, exp, act);
            end_with_failure();
        end
    endtask

    // expected response from the sizing rules with memory updated in command order
    task automatic model_command(input int idx);
        int               nbytes;
        logic             mis;
        logic             file_err;
        logic [ADR_W-1:0] a;
        logic [DAT_W-1:0] rdt;
        nbytes   = 1 << cmd_siz;
        mis      = (int'(cmd_adr) % nbytes) != 0;
        file_err = stim_words[5*idx+4][0];
        rdt      = '0;
        if (mis !== file_err) begin
            $display("stimulus line %0d has an error flag that contradicts its address", idx);
            end_with_failure();
        end else begin
            // misaligned accesses write nothing and read zero
            if (!mis) begin
                for (int b = 0; b < nbytes; b++) begin
                    a = cmd_adr + ADR_W'(b);
                    if (cmd_wen) begin
                        ref_mem[a] = cmd_wdt[8*b +: 8];
                    end else begin
                        rdt[8*b +: 8] = ref_mem[a];
                    end
                end
            end
            exp_wen_q.push_back(cmd_wen);
            exp_err_q.push_back(file_err);
            exp_rdt_q.push_back(rdt);
        end
    endtask

    task automatic check_response();
        if (exp_rdt_q.size() == 0) begin
            $display("a response arrived at %0d ns with no command outstanding", $time);
            end_with_failure();
        end else begin
            check_flag("rsp_wen", exp_wen_q.pop_front(), rsp_wen);
            check_flag("rsp_err", exp_err_q.pop_front(), rsp_err);
            check_data("rsp_rdt", exp_rdt_q.pop_front(), rsp_rdt);
            n_rsp++;
        end
    endtask

    ////////////////////////////////////////
    // clock, back-pressure, timeout
    ////////////////////////////////////////

    initial begin
        forever #2 mon = ~mon;
    end

    // rsp_rdy about 70% high and forced low for the stall window
    initial begin
        rnd_state = 32'hf082;
        rsp_rdy   = 1'b0;
        forever begin
            @(negedge mon);
            if (stall_left > 0) begin
                rsp_rdy = 1'b0;
                stall_left--;
            end else begin
                rnd_state = next_random(rnd_state);
                rsp_rdy   = (rnd_state % 10) < 7;
            end
        end
    end

    always @(posedge mon) begin
        cyc++;
        if (cyc > cycle_limit) begin
            $display("timeout after %0d cycles, %0d of %0d responses seen", cyc, n_rsp, ncmd);
            end_with_failure();
        end
    end

    ////////////////////////////////////////
    // monitor sampling on the rising edge
    ////////////////////////////////////////

    always @(posedge mon) begin
        if (rst_n) begin
            if (rsp_vld !== 1'b0 && n_acc == 0) begin
                $display("rsp_vld not low at %0d ns before any command was accepted", $time);
                end_with_failure();
            end
            // responses before accepts so an accept in the same edge cannot mask a spurious one
            if (rsp_vld && rsp_rdy) begin
                check_response();
            end
            if (cmd_vld && cmd_rdy) begin
                model_command(n_acc);
                n_acc++;
                if (n_acc == STALL_AT) begin
                    stall_left = STALL_CYC;
                end
            end
            if (stall_left > 0 && !cmd_rdy) begin
                saw_full = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial begin
        rst_n      = 1'b0;
        cmd_vld    = 1'b0;
        cmd_wen    = 1'b0;
        cmd_adr    = '0;
        cmd_siz    = '0;
        cmd_wdt    = '0;
        n_acc      = 0;
        n_rsp      = 0;
        cyc        = 0;
        stall_left = 0;
        saw_full   = 1'b0;
        ncmd       = 0;

        // all ones marks the end of the file data
        for (int i = 0; i < 5*MAX_CMD; i++) begin
            stim_words[i] = 32'hffff_ffff;
        end
        $readmemh("bench/tcb_lite_stimulus.txt", stim_words);
        while (ncmd < MAX_CMD && stim_words[5*ncmd] != 32'hffff_ffff) begin
            ncmd++;
        end
        cycle_limit = 20 * ncmd + 100;
        if (ncmd == 0) begin
            $display("no commands found in the stimulus file");
            end_with_failure();
        end

        repeat (3) @(posedge mon);
        @(negedge mon);
        rst_n = 1'b1;

        // idle a while with rsp_vld low
        repeat (4) @(negedge mon);

        for (int i = 0; i < ncmd; i++) begin
            cmd_vld = 1'b1;
            cmd_wen = stim_words[5*i][0];
            cmd_adr = stim_words[5*i+1][ADR_W-1:0];
            cmd_siz = stim_words[5*i+2][SIZ_W-1:0];
            cmd_wdt = stim_words[5*i+3];
            // hold until taken
            do begin
                @(posedge mon);
            end while (!cmd_rdy);
            @(negedge mon);
        end
        cmd_vld = 1'b0;

        wait (n_rsp == ncmd);
        // window to catch a duplicated response
        repeat (10) @(posedge mon);

        if (!saw_full) begin
            $display("cmd_rdy never fell while rsp_rdy was held low");
            end_with_failure();
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule: tcb_lite_tb

`default_nettype wire

/* bench/tcb_lite_protocol_sva.sv */
// TCB-Lite bus protocol assertions
// bound into the subsystem top on the internal bus

`default_nettype none

module tcb_lite_protocol_sva
    import tcb_lite_pkg::*;
(
    input logic             mon,
    input logic             rst_n,
    input logic             tcb_vld,
    input logic             tcb_rdy,
    input logic             tcb_wen,
    input logic [ADR_W-1:0] tcb_adr,
    input logic [SIZ_W-1:0] tcb_siz,
    input logic [DAT_W-1:0] tcb_wdt,
    input logic [DAT_W-1:0] tcb_rdt,
    input logic             tcb_err
);

    timeunit 1ns;
    timeprecision 100ps;

    // bytes below 2^siz
    function automatic logic [DAT_W-1:0] read_mask(input logic [SIZ_W-1:0] siz);
        logic [DAT_W-1:0] msk;
        msk = '0;
        for (int j = 0; j < BYT; j++) begin
            if (j < (1 << siz)) begin
                msk[8*j +: 8] = 8'hff;
            end
        end
        return msk;
    endfunction

    ////////////////////////////////////////
    // handshake layer
    ////////////////////////////////////////

    // quiet from the second reset cycle through the first cycle after release
    a_rst_quiet: assert property (@(posedge mon) $past(!rst_n) |-> (tcb_vld === 1'b0))
        else $error("tcb_vld not low around reset");

    a_vld_known: assert property (@(posedge mon) disable iff (!rst_n) !$isunknown(tcb_vld))
        else $error("tcb_vld unknown");

    ////////////////////////////////////////
    // bus layer
    ////////////////////////////////////////

    a_req_known: assert property (@(posedge mon) disable iff (!rst_n)
        tcb_vld |-> !$isunknown({tcb_wen, tcb_adr, tcb_siz}))
        else $error("request fields unknown while valid");

    a_wdt_known: assert property (@(posedge mon) disable iff (!rst_n)
        (tcb_vld && tcb_wen) |-> !$isunknown(tcb_wdt))
        else $error("write data unknown");

    a_siz_range: assert property (@(posedge mon) disable iff (!rst_n)
        tcb_vld |-> (tcb_siz <= SIZ_W'(SIZ_MAX)))
        else $error("tcb_siz above the largest size");

    // read response DLY cycles after the transfer
    a_rsp_known: assert property (@(posedge mon) disable iff (!rst_n)
        (tcb_vld && tcb_rdy && !tcb_wen) |-> ##DLY
        (!$isunknown(tcb_err) &&
         (tcb_err || !$isunknown(tcb_rdt & read_mask($past(tcb_siz, DLY))))))
        else $error("read response unknown");

endmodule: tcb_lite_protocol_sva

bind tcb_lite_top tcb_lite_protocol_sva u_protocol_sva (
    .mon     (mon),
    .rst_n   (rst_n),
    .tcb_vld (tcb_vld),
    .tcb_rdy (tcb_rdy),
    .tcb_wen (tcb_wen),
    .tcb_adr (tcb_adr),
    .tcb_siz (tcb_siz),
    .tcb_wdt (tcb_wdt),
    .tcb_rdt (tcb_rdt),
    .tcb_err (tcb_err)
);

`default_nettype wire

/* design/tcb_lite_top.sv */
// TCB-Lite subsystem top
// request queue, memory subordinate and response buffer on one bus

`default_nettype none

module tcb_lite_top
    import tcb_lite_pkg::*;
(
    input  logic             mon,
    input  logic             rst_n,
    // command stream
    input  logic             cmd_vld,
    output logic             cmd_rdy,
    input  logic             cmd_wen,
    input  logic [ADR_W-1:0] cmd_adr,
    input  logic [SIZ_W-1:0] cmd_siz,
    input  logic [DAT_W-1:0] cmd_wdt,
    // response stream
    output logic             rsp_vld,
    input  logic             rsp_rdy,
    output logic             rsp_wen,
    output logic [DAT_W-1:0] rsp_rdt,
    output logic             rsp_err
);

    ////////////////////////////////////////
    // internal bus
    ////////////////////////////////////////

    // request
    logic             tcb_vld;
    logic             tcb_rdy;
    logic             tcb_wen;
    logic [ADR_W-1:0] tcb_adr;
    logic [SIZ_W-1:0] tcb_siz;
    logic [DAT_W-1:0] tcb_wdt;
    // response
    logic [DAT_W-1:0] tcb_rdt;
    logic             tcb_err;
    // credits
    logic             crd_ret;

    // manager side
    tcb_lite_req_queue u_req_queue (
        .mon     (mon),
        .rst_n   (rst_n),
        .cmd_vld (cmd_vld),
        .cmd_rdy (cmd_rdy),
        .cmd_wen (cmd_wen),
        .cmd_adr (cmd_adr),
        .cmd_siz (cmd_siz),
        .cmd_wdt (cmd_wdt),
        .tcb_vld (tcb_vld),
        .tcb_rdy (tcb_rdy),
        .tcb_wen (tcb_wen),
        .tcb_adr (tcb_adr),
        .tcb_siz (tcb_siz),
        .tcb_wdt (tcb_wdt),
        .crd_ret (crd_ret)
    );

    // subordinate
    tcb_lite_mem u_mem (
        .mon     (mon),
        .rst_n   (rst_n),
        .tcb_vld (tcb_vld),
        .tcb_rdy (tcb_rdy),
        .tcb_wen (tcb_wen),
        .tcb_adr (tcb_adr),
        .tcb_siz (tcb_siz),
        .tcb_wdt (tcb_wdt),
        .tcb_rdt (tcb_rdt),
        .tcb_err (tcb_err)
    );

    // response return path
    tcb_lite_rsp_buffer u_rsp_buffer (
        .mon     (mon),
        .rst_n   (rst_n),
        .tcb_vld (tcb_vld),
        .tcb_rdy (tcb_rdy),
        .tcb_wen (tcb_wen),
        .tcb_siz (tcb_siz),
        .tcb_rdt (tcb_rdt),
        .tcb_err (tcb_err),
        .rsp_vld (rsp_vld),
        .rsp_rdy (rsp_rdy),
        .rsp_wen (rsp_wen),
        .rsp_rdt (rsp_rdt),
        .rsp_err (rsp_err),
        .crd_ret (crd_ret)
    );

endmodule: tcb_lite_top

`default_nettype wire

/* design/tcb_lite_rsp_buffer.sv */
// response FIFO fed by delayed TCB-Lite responses
// drains to the response stream and returns credits

`default_nettype none

module tcb_lite_rsp_buffer
    import tcb_lite_pkg::*;
(
    input  logic             mon,
    input  logic             rst_n,
    // tcb request side, for the delay line
    input  logic             tcb_vld,
    input  logic             tcb_rdy,
    input  logic             tcb_wen,
    input  logic [SIZ_W-1:0] tcb_siz,
    // tcb response
    input  logic [DAT_W-1:0] tcb_rdt,
    input  logic             tcb_err,
    // response stream
    output logic             rsp_vld,
    input  logic             rsp_rdy,
    output logic             rsp_wen,
    output logic [DAT_W-1:0] rsp_rdt,
    output logic             rsp_err,
    // credit return to request queue
    output logic             crd_ret
);

    // transfer delay line
    logic             vld_dly [DLY];
    logic             wen_dly [DLY];
    logic [SIZ_W-1:0] siz_dly [DLY];

    // response storage
    logic             fif_wen [RSP_DEPTH];
    logic [DAT_W-1:0] fif_rdt [RSP_DEPTH];
    logic             fif_err [RSP_DEPTH];

    logic [RSP_PW-1:0] wr_ptr;
    logic [RSP_PW-1:0] rd_ptr;
    logic [CRD_W-1:0]  cnt;
    logic              psh;
    logic              pop;
    logic [DAT_W-1:0]  psh_rdt;

    ////////////////////////////////////////
    // delay line matching the subordinate
    ////////////////////////////////////////

    always_ff @(posedge mon) begin
        if (!rst_n) begin
            for (int k = 0; k < DLY; k++) begin
                vld_dly[k] <= 1'b0;
            end
        end else begin
            vld_dly[0] <= tcb_vld & tcb_rdy;
            for (int k = 1; k < DLY; k++) begin
                vld_dly[k] <= vld_dly[k-1];
            end
        end
    end

    always_ff @(posedge mon) begin
        wen_dly[0] <= tcb_wen;
        siz_dly[0] <= tcb_siz;
        for (int k = 1; k < DLY; k++) begin
            wen_dly[k] <= wen_dly[k-1];
            siz_dly[k] <= siz_dly[k-1];
        end
    end

    // clear bytes above the size, all of it for writes and errors
    always_comb begin
        psh_rdt = '0;
        if (!wen_dly[DLY-1] && !tcb_err) begin
            for (int j = 0; j < BYT; j++) begin
                if (j < (1 << siz_dly[DLY-1])) begin
                    psh_rdt[8*j +: 8] = tcb_rdt[8*j +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////
    // response fifo
    ////////////////////////////////////////

    // credits keep a push from ever seeing a full fifo
    assign psh = vld_dly[DLY-1];
    assign rsp_vld = (cnt != '0);
    assign pop = rsp_vld & rsp_rdy;
    // one credit back per drained entry
    assign crd_ret = pop;

    assign rsp_wen = fif_wen[rd_ptr];
    assign rsp_rdt = fif_rdt[rd_ptr];
    assign rsp_err = fif_err[rd_ptr];

    always_ff @(posedge mon) begin
        if (psh) begin
            fif_wen[wr_ptr] <= wen_dly[DLY-1];
            fif_rdt[wr_ptr] <= psh_rdt;
            fif_err[wr_ptr] <= tcb_err;
        end
    end

    always_ff @(posedge mon) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (psh) begin
                wr_ptr <= (wr_ptr == RSP_PW'(RSP_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == RSP_PW'(RSP_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({psh, pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
        end
    end

endmodule: tcb_lite_rsp_buffer

`default_nettype wire

/* design/tcb_lite_mem.sv */
// TCB-Lite memory subordinate, logical-size mode
// alignment check, byte-lane steering, delayed response

`default_nettype none

module tcb_lite_mem
    import tcb_lite_pkg::*;
(
    input  logic             mon,
    input  logic             rst_n,
    // tcb request
    input  logic             tcb_vld,
    output logic             tcb_rdy,
    input  logic             tcb_wen,
    input  logic [ADR_W-1:0] tcb_adr,
    input  logic [SIZ_W-1:0] tcb_siz,
    input  logic [DAT_W-1:0] tcb_wdt,
    // tcb response
    output logic [DAT_W-1:0] tcb_rdt,
    output logic             tcb_err
);

    // one byte array per lane
    logic [7:0] mem_lane [BYT][2**(ADR_W-SIZ_MAX)];

    logic [ADR_W-SIZ_MAX-1:0] wrd_adr;
    logic [SIZ_MAX-1:0]       off;
    logic [SIZ_MAX-1:0]       off_msk;
    logic                     trn;
    logic                     mis;
    logic [BYT-1:0]           lane_en;
    logic [7:0]               lane_wdt [BYT];
    logic [7:0]               lane_rdt [BYT];
    logic [DAT_W-1:0]         rdt_aln;

    // response delay line
    logic [DAT_W-1:0] rdt_pip [DLY];
    logic             err_pip [DLY];

    // never stalls
    assign tcb_rdy = 1'b1;
    assign trn = tcb_vld & tcb_rdy;

    ////////////////////////////////////////
    // address decode and lane steering
    ////////////////////////////////////////

    assign wrd_adr = tcb_adr[ADR_W-1:SIZ_MAX];
    assign off     = tcb_adr[SIZ_MAX-1:0];

    // offset bits that must be zero for this size
    assign off_msk = SIZ_MAX'((1 << tcb_siz) - 1);
    assign mis = |(off & off_msk);

    always_comb begin
        for (int i = 0; i < BYT; i++) begin
            // lane position relative to the start byte
            lane_en[i]  = ((SIZ_MAX'(i) - off) <= off_msk);
            lane_wdt[i] = tcb_wdt[8*(SIZ_MAX'(i) - off) +: 8];
            lane_rdt[i] = mem_lane[i][wrd_adr];
        end
        // rotate start lane down to byte 0
        for (int j = 0; j < BYT; j++) begin
            rdt_aln[8*j +: 8] = lane_rdt[SIZ_MAX'(j) + off];
        end
    end

    ////////////////////////////////////////
    // storage
    ////////////////////////////////////////

    // misaligned writes are dropped
    always_ff @(posedge mon) begin
        if (trn && tcb_wen && !mis) begin
            for (int i = 0; i < BYT; i++) begin
                if (lane_en[i]) begin
                    mem_lane[i][wrd_adr] <= lane_wdt[i];
                end
            end
        end
    end

    ////////////////////////////////////////
    // response pipeline
    ////////////////////////////////////////

    // read data, upper bytes keep whatever the lanes held
    always_ff @(posedge mon) begin
        rdt_pip[0] <= rdt_aln;
        for (int k = 1; k < DLY; k++) begin
            rdt_pip[k] <= rdt_pip[k-1];
        end
    end

    // error flag only for real transfers
    always_ff @(posedge mon) begin
        if (!rst_n) begin
            for (int k = 0; k < DLY; k++) begin
                err_pip[k] <= 1'b0;
            end
        end else begin
            err_pip[0] <= trn & mis;
            for (int k = 1; k < DLY; k++) begin
                err_pip[k] <= err_pip[k-1];
            end
        end
    end

    assign tcb_rdt = rdt_pip[DLY-1];
    assign tcb_err = err_pip[DLY-1];

endmodule: tcb_lite_mem

`default_nettype wire

/* design/tcb_lite_req_queue.sv */
// command FIFO with credit counter
// turns the command stream into TCB-Lite request transfers

`default_nettype none

module tcb_lite_req_queue
    import tcb_lite_pkg::*;
(
    input  logic             mon,
    input  logic             rst_n,
    // command stream
    input  logic             cmd_vld,
    output logic             cmd_rdy,
    input  logic             cmd_wen,
    input  logic [ADR_W-1:0] cmd_adr,
    input  logic [SIZ_W-1:0] cmd_siz,
    input  logic [DAT_W-1:0] cmd_wdt,
    // tcb request
    output logic             tcb_vld,
    input  logic             tcb_rdy,
    output logic             tcb_wen,
    output logic [ADR_W-1:0] tcb_adr,
    output logic [SIZ_W-1:0] tcb_siz,
    output logic [DAT_W-1:0] tcb_wdt,
    // credit return from response buffer
    input  logic             crd_ret
);

    // command storage
    logic             fif_wen [CMD_DEPTH];
    logic [ADR_W-1:0] fif_adr [CMD_DEPTH];
    logic [SIZ_W-1:0] fif_siz [CMD_DEPTH];
    logic [DAT_W-1:0] fif_wdt [CMD_DEPTH];

    logic [CMD_PW-1:0] wr_ptr;
    logic [CMD_PW-1:0] rd_ptr;
    logic [CMD_CW-1:0] cnt;
    logic [CRD_W-1:0]  crd;
    logic              psh;
    logic              pop;

    ////////////////////////////////////////
    // handshakes
    ////////////////////////////////////////

    // room left in the fifo
    assign cmd_rdy = (cnt != CMD_CW'(CMD_DEPTH));
    assign psh = cmd_vld & cmd_rdy;

    // issue only with a command and a free response slot
    assign tcb_vld = (cnt != '0) && (crd != '0);
    assign pop = tcb_vld & tcb_rdy;

    // head of fifo drives the bus
    assign tcb_wen = fif_wen[rd_ptr];
    assign tcb_adr = fif_adr[rd_ptr];
    assign tcb_siz = fif_siz[rd_ptr];
    assign tcb_wdt = fif_wdt[rd_ptr];

    ////////////////////////////////////////
    // storage and pointers
    ////////////////////////////////////////

    // payload write
    always_ff @(posedge mon) begin
        if (psh) begin
            fif_wen[wr_ptr] <= cmd_wen;
            fif_adr[wr_ptr] <= cmd_adr;
            fif_siz[wr_ptr] <= cmd_siz;
            fif_wdt[wr_ptr] <= cmd_wdt;
        end
    end

    always_ff @(posedge mon) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
            crd    <= CRD_W'(RSP_DEPTH);
        end else begin
            // wrapping pointers
            if (psh) begin
                wr_ptr <= (wr_ptr == CMD_PW'(CMD_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == CMD_PW'(CMD_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // occupancy
            case ({psh, pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;
            endcase
            // spend on transfer, restore on return, both may coincide
            case ({pop, crd_ret})
                2'b10:   crd <= crd - 1'b1;
                2'b01:   crd <= crd + 1'b1;
                default: crd <= crd;
            endcase
        end
    end

endmodule: tcb_lite_req_queue

`default_nettype wire

/* design/tcb_lite_pkg.sv */
// bus widths, transfer size range, response delay
// and queue depths for the TCB-Lite subsystem

`default_nettype none

package tcb_lite_pkg;

    ////////////////////////////////////////
    // bus geometry
    ////////////////////////////////////////

    // byte address
    localparam int ADR_W = 10;
    // data word
    localparam int DAT_W = 32;
    // byte lanes per word
    localparam int BYT = DAT_W / 8;

    // size code is log2 of the byte count
    localparam int SIZ_W = 2;
    // 2 means a full 4-byte word
    localparam int SIZ_MAX = 2;

    ////////////////////////////////////////
    // timing and buffering
    ////////////////////////////////////////

    // subordinate read delay in cycles
    localparam int DLY = 1;

    // response entries, equal to the credit count
    localparam int RSP_DEPTH = 4;
    // command entries
    localparam int CMD_DEPTH = 2;

    // pointer and counter widths
    localparam int CMD_PW = $clog2(CMD_DEPTH);
    localparam int CMD_CW = $clog2(CMD_DEPTH + 1);
    localparam int RSP_PW = $clog2(RSP_DEPTH);
    localparam int CRD_W = $clog2(RSP_DEPTH + 1);

endpackage: tcb_lite_pkg

`default_nettype wire
